// File: verilog/csr_isa_pkg.sv
`default_nettype none

package csr_isa_pkg;

    localparam int XLEN = 32;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_t;

    typedef enum logic [2:0] {
        SYS_NONE,
        SYS_ECALL,
        SYS_EBREAK,
        SYS_MRET,
        SYS_CSR_SWAP,
        SYS_CSR_SET,
        SYS_CSR_CLEAR
    } sys_op_t;

    // exception causes
    localparam logic [4:0] CAUSE_EBREAK  = 5'd3;
    localparam logic [4:0] CAUSE_ECALL_U = 5'd8;
    localparam logic [4:0] CAUSE_ECALL_M = 5'd11;

    // interrupt codes, also the bit index in mip/mie
    localparam logic [4:0] INT_MSI = 5'd3;
    localparam logic [4:0] INT_MTI = 5'd7;
    localparam logic [4:0] INT_MEI = 5'd11;

    // except_code values the pipeline uses as markers, above the standard codes
    localparam logic [4:0] EXC_MARK_SYS = 5'd24;  // system instruction, see sys_op
    localparam logic [4:0] EXC_MARK_INT = 5'd25;  // interrupt taken on this instruction

    localparam logic [11:0] CSR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_MISA     = 12'h301;
    localparam logic [11:0] CSR_MIE      = 12'h304;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;
    localparam logic [11:0] CSR_MTVAL    = 12'h343;
    localparam logic [11:0] CSR_MIP      = 12'h344;
    localparam logic [11:0] CSR_CYCLE    = 12'hc00;
    localparam logic [11:0] CSR_CYCLEH   = 12'hc80;
    localparam logic [11:0] CSR_MHARTID  = 12'hf14;

    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;
    localparam int MPP_LO   = 11;  // MPP is [12:11]

    // rv32 with A, C, I and M
    localparam logic [XLEN-1:0] MISA_VALUE  = 32'h4000_1105;
    localparam logic [XLEN-1:0] MIP_SW_MASK = 32'h0000_0888;  // software-writable mip bits

endpackage

`default_nettype wire

// File: verilog/csr_pipe_pkg.sv
`default_nettype none

package csr_pipe_pkg;

    // one instruction leaving the memory stage
    typedef struct packed {
        logic                              valid;
        logic [csr_isa_pkg::XLEN-1:0]      pc;
        logic                              except_valid;
        logic [4:0]                        except_code;
        logic [csr_isa_pkg::XLEN-1:0]      tval;
        csr_isa_pkg::sys_op_t              sys_op;
        logic [11:0]                       csr_addr;
    } stage_in_t;

    typedef enum logic [2:0] {
        EV_NONE,
        EV_EXCEPT,
        EV_INT,
        EV_ECALL,
        EV_EBREAK,
        EV_MRET,
        EV_CSR,
        EV_OTHER_TRAP
    } event_kind_t;

    typedef struct packed {
        logic                              valid;
        event_kind_t                       kind;
        logic [csr_isa_pkg::XLEN-1:0]      pc;
        logic [4:0]                        code;
        logic [csr_isa_pkg::XLEN-1:0]      tval;
        logic [11:0]                       csr_addr;
        csr_isa_pkg::sys_op_t              op;
    } sys_event_t;

    typedef struct packed {
        logic                              valid;
        logic [csr_isa_pkg::XLEN-1:0]      pc;
        logic                              redirect;  // o_data is a jump target
    } wb_out_t;

endpackage

`default_nettype wire

// File: verilog/sys_event_decode.sv
`timescale 1ns/1ps
`default_nettype none

module sys_event_decode (
    input  wire csr_pipe_pkg::stage_in_t  i_instr,
    output csr_pipe_pkg::sys_event_t      o_event
);
    import csr_isa_pkg::*;
    import csr_pipe_pkg::*;

    event_kind_t kind;

    always_comb begin
        kind = EV_NONE;  // plain or invalid instruction
        if (i_instr.valid && i_instr.except_valid) begin
            if (i_instr.except_code == EXC_MARK_INT) begin
                kind = EV_INT;
            end else if (i_instr.except_code == EXC_MARK_SYS) begin
                case (i_instr.sys_op)
                    SYS_ECALL:     kind = EV_ECALL;
                    SYS_EBREAK:    kind = EV_EBREAK;
                    SYS_MRET:      kind = EV_MRET;
                    SYS_CSR_SWAP,
                    SYS_CSR_SET,
                    SYS_CSR_CLEAR: kind = EV_CSR;
                    SYS_NONE:      kind = EV_OTHER_TRAP;
                    default:       kind = EV_OTHER_TRAP;
                endcase
            end else begin
                kind = EV_EXCEPT;  // standard exception code
            end
        end
    end

    assign o_event = '{
        valid:    i_instr.valid,
        kind:     kind,
        pc:       i_instr.pc,
        code:     i_instr.except_code,
        tval:     i_instr.tval,
        csr_addr: i_instr.csr_addr,
        op:       i_instr.sys_op
    };

endmodule

`default_nettype wire

// File: verilog/machine_csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module machine_csr_file (
    input  wire logic                          i_clk,
    input  wire logic                          i_rst_n,
    input  wire logic                          i_flush,
    input  wire csr_pipe_pkg::sys_event_t      i_event,
    input  wire logic [csr_isa_pkg::XLEN-1:0]  i_data,
    input  wire logic                          i_int_ext,
    input  wire logic                          i_int_timer,
    input  wire logic                          i_int_soft,
    output logic                               o_redirect,
    output logic [csr_isa_pkg::XLEN-1:0]       o_result,
    output csr_isa_pkg::priv_t                 o_priv,
    output logic [csr_isa_pkg::XLEN-1:0]       o_status,
    output logic [11:0]                        o_intp,
    output logic [11:0]                        o_inte
);
    import csr_isa_pkg::*;
    import csr_pipe_pkg::*;

    priv_t            priv;
    logic [XLEN-1:0]  mstatus;
    logic [XLEN-1:0]  mie;
    logic [XLEN-1:0]  mip_sw;
    logic [XLEN-1:0]  mtvec;
    logic [XLEN-1:0]  mscratch;
    logic [XLEN-1:0]  mepc;
    logic [XLEN-1:0]  mcause;
    logic [XLEN-1:0]  mtval;
    logic [63:0]      cycle_cnt;

    logic [XLEN-1:0]  mip;
    logic [XLEN-1:0]  int_ready;
    logic [4:0]       int_code;
    logic             is_trap;
    logic             is_csr;
    logic [XLEN-1:0]  csr_old;
    logic [XLEN-1:0]  csr_new;
    logic [XLEN-1:0]  trap_cause;
    logic [XLEN-1:0]  trap_tval;
    logic [XLEN-1:0]  trap_status;

    // only MIE, MPIE and MPP exist, MPP collapses to U or M
    function automatic logic [XLEN-1:0] status_wr(input logic [XLEN-1:0] v);
        logic [XLEN-1:0] s;
        s = '0;
        s[MIE_BIT]      = v[MIE_BIT];
        s[MPIE_BIT]     = v[MPIE_BIT];
        s[MPP_LO +: 2]  = (v[MPP_LO +: 2] != 2'b00) ? PRIV_MACHINE : PRIV_USER;
        return s;
    endfunction

    assign mip       = mip_sw | {20'b0, i_int_ext, 3'b0, i_int_timer, 3'b0, i_int_soft, 3'b0};
    assign int_ready = mip & mie;
    assign is_trap   = i_event.kind inside {EV_EXCEPT, EV_INT, EV_ECALL, EV_EBREAK};
    assign is_csr    = (i_event.kind == EV_CSR);

    always_comb begin  // MEI > MSI > MTI
        if (int_ready[INT_MEI]) begin
            int_code = INT_MEI;
        end else if (int_ready[INT_MSI]) begin
            int_code = INT_MSI;
        end else if (int_ready[INT_MTI]) begin
            int_code = INT_MTI;
        end else begin
            int_code = 5'd0;
        end
    end

    always_comb begin
        trap_tval = '0;
        case (i_event.kind)
            EV_EXCEPT: begin
                trap_cause = {{(XLEN-5){1'b0}}, i_event.code};
                trap_tval  = i_event.tval;
            end
            EV_ECALL: begin
                trap_cause = {{(XLEN-5){1'b0}},
                              (priv == PRIV_USER) ? CAUSE_ECALL_U : CAUSE_ECALL_M};
            end
            EV_EBREAK: begin
                trap_cause = {{(XLEN-5){1'b0}}, CAUSE_EBREAK};
                trap_tval  = i_event.pc;
            end
            default: trap_cause = {1'b1, {(XLEN-6){1'b0}}, int_code};  // interrupt
        endcase
        trap_status                 = mstatus;
        trap_status[MPP_LO +: 2]    = priv;
        trap_status[MPIE_BIT]       = mstatus[MIE_BIT];
        trap_status[MIE_BIT]        = 1'b0;
    end

    always_comb begin
        case (i_event.csr_addr)
            CSR_MSTATUS:  csr_old = mstatus;
            CSR_MISA:     csr_old = MISA_VALUE;
            CSR_MIE:      csr_old = mie;
            CSR_MTVEC:    csr_old = mtvec;
            CSR_MSCRATCH: csr_old = mscratch;
            CSR_MEPC:     csr_old = mepc;
            CSR_MCAUSE:   csr_old = mcause;
            CSR_MTVAL:    csr_old = mtval;
            CSR_MIP:      csr_old = mip;  // hardware levels included
            CSR_CYCLE:    csr_old = cycle_cnt[31:0];
            CSR_CYCLEH:   csr_old = cycle_cnt[63:32];
            CSR_MHARTID:  csr_old = '0;
            default:      csr_old = '0;
        endcase
        case (i_event.op)
            SYS_CSR_SWAP:  csr_new = i_data;
            SYS_CSR_SET:   csr_new = csr_old | i_data;
            SYS_CSR_CLEAR: csr_new = csr_old & ~i_data;
            default:       csr_new = csr_old;
        endcase
    end

    always_comb begin
        o_redirect = 1'b0;
        o_result   = i_data;  // pass-through for plain instructions
        if (is_trap) begin
            o_redirect = 1'b1;
            o_result   = mtvec;
        end else if (i_event.kind == EV_MRET) begin
            o_redirect = 1'b1;
            o_result   = {mepc[XLEN-1:1], 1'b0};
        end else if (is_csr) begin
            o_result = csr_old;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            priv     <= PRIV_MACHINE;
            mstatus  <= '0;
            mie      <= '0;
            mip_sw   <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (!i_flush) begin
            if (is_trap) begin
                mepc    <= i_event.pc;
                mcause  <= trap_cause;
                mtval   <= trap_tval;
                mstatus <= trap_status;
                priv    <= PRIV_MACHINE;
            end else if (i_event.kind == EV_MRET) begin
                mstatus[MIE_BIT] <= mstatus[MPIE_BIT];
                priv             <= priv_t'(mstatus[MPP_LO +: 2]);
            end else if (is_csr) begin
                case (i_event.csr_addr)
                    CSR_MSTATUS:  mstatus  <= status_wr(csr_new);
                    CSR_MIE:      mie      <= csr_new;
                    CSR_MTVEC:    mtvec    <= csr_new;
                    CSR_MSCRATCH: mscratch <= csr_new;
                    CSR_MEPC:     mepc     <= csr_new;
                    CSR_MCAUSE:   mcause   <= csr_new;
                    CSR_MTVAL:    mtval    <= csr_new;
                    CSR_MIP:      mip_sw   <= csr_new & MIP_SW_MASK;
                    default:      ;  // read only or unknown
                endcase
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 64'd1;  // runs through flush too
        end
    end

    assign o_priv   = priv;
    assign o_status = mstatus;
    assign o_intp   = mip[11:0];
    assign o_inte   = mie[11:0];

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        priv inside {PRIV_USER, PRIV_MACHINE})
        else $error("illegal privilege %0d", priv);

endmodule

`default_nettype wire

// File: verilog/wb_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage_reg (
    input  wire logic                          i_clk,
    input  wire logic                          i_rst_n,
    input  wire logic                          i_flush,
    input  wire csr_pipe_pkg::sys_event_t      i_event,
    input  wire logic                          i_redirect,
    input  wire logic [csr_isa_pkg::XLEN-1:0]  i_result,
    output csr_pipe_pkg::wb_out_t              o_wb,
    output logic [csr_isa_pkg::XLEN-1:0]       o_data
);
    import csr_isa_pkg::*;

    logic             valid_q;
    logic             redirect_q;
    logic [XLEN-1:0]  pc_q;
    logic [XLEN-1:0]  data_q;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_flush) begin
            valid_q    <= 1'b0;
            redirect_q <= 1'b0;
        end else begin
            valid_q    <= i_event.valid;  // trapped instructions stay valid as jump items
            redirect_q <= i_redirect;
        end
    end

    always_ff @(posedge i_clk) begin
        pc_q   <= i_event.pc;
        data_q <= i_result;  // target or rd value
    end

    assign o_wb   = '{valid: valid_q, pc: pc_q, redirect: redirect_q};
    assign o_data = data_q;

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb.redirect |-> o_wb.valid)
        else $error("redirect without valid at pc %h", o_wb.pc);

endmodule

`default_nettype wire

// File: verilog/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
    input  wire logic                          i_clk,
    input  wire logic                          i_rst_n,
    input  wire csr_pipe_pkg::stage_in_t       i_instr,
    input  wire logic [csr_isa_pkg::XLEN-1:0]  i_data,   // rs1 or pass-through
    input  wire logic                          i_flush,
    input  wire logic                          i_int_ext,
    input  wire logic                          i_int_timer,
    input  wire logic                          i_int_soft,
    output csr_pipe_pkg::wb_out_t              o_wb,
    output logic [csr_isa_pkg::XLEN-1:0]       o_data,
    output csr_isa_pkg::priv_t                 o_priv,
    output logic [csr_isa_pkg::XLEN-1:0]       o_status,
    output logic [11:0]                        o_intp,
    output logic [11:0]                        o_inte
);
    import csr_isa_pkg::*;
    import csr_pipe_pkg::*;

    sys_event_t       sys_event;
    logic             redirect;
    logic [XLEN-1:0]  result;

    sys_event_decode u_decode (
        .i_instr (i_instr),
        .o_event (sys_event)
    );

    machine_csr_file u_csr_file (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_flush     (i_flush),
        .i_event     (sys_event),
        .i_data      (i_data),
        .i_int_ext   (i_int_ext),
        .i_int_timer (i_int_timer),
        .i_int_soft  (i_int_soft),
        .o_redirect  (redirect),
        .o_result    (result),
        .o_priv      (o_priv),
        .o_status    (o_status),
        .o_intp      (o_intp),
        .o_inte      (o_inte)
    );

    wb_stage_reg u_wb_reg (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_flush    (i_flush),
        .i_event    (sys_event),
        .i_redirect (redirect),
        .i_result   (result),
        .o_wb       (o_wb),
        .o_data     (o_data)
    );

endmodule

`default_nettype wire

// File: test/csr_ref_model.svh
`ifndef CSR_REF_MODEL_SVH
`define CSR_REF_MODEL_SVH

// machine state as the checker expects it
logic [1:0]  m_priv;
logic [31:0] m_status;
logic [31:0] m_mie;
logic [31:0] m_mip_sw;
logic [31:0] m_mtvec;
logic [31:0] m_mscratch;
logic [31:0] m_mepc;
logic [31:0] m_mcause;
logic [31:0] m_mtval;
logic [63:0] m_cycle;

// rv32 in the top bits, then the letters A, C, I and M
localparam logic [31:0] M_MISA = 32'h4000_0000 | (32'd1 << 0) | (32'd1 << 2)
                                 | (32'd1 << 8) | (32'd1 << 12);

task automatic init_state();
    m_priv     = 2'b11;
    m_status   = '0;
    m_mie      = '0;
    m_mip_sw   = '0;
    m_mtvec    = '0;
    m_mscratch = '0;
    m_mepc     = '0;
    m_mcause   = '0;
    m_mtval    = '0;
    m_cycle    = 64'd1;  // count seen in the first cycle after reset
endtask

// ints is {ext, timer, soft}
function automatic logic [31:0] mip_view(input logic [2:0] ints);
    logic [31:0] v;
    v     = m_mip_sw;
    v[11] = v[11] | ints[2];
    v[7]  = v[7] | ints[1];
    v[3]  = v[3] | ints[0];
    return v;
endfunction

function automatic logic [31:0] lookup_csr(input logic [11:0] addr, input logic [2:0] ints);
    case (addr)
        CSR_MSTATUS:  return m_status;
        CSR_MISA:     return M_MISA;
        CSR_MIE:      return m_mie;
        CSR_MTVEC:    return m_mtvec;
        CSR_MSCRATCH: return m_mscratch;
        CSR_MEPC:     return m_mepc;
        CSR_MCAUSE:   return m_mcause;
        CSR_MTVAL:    return m_mtval;
        CSR_MIP:      return mip_view(ints);
        CSR_CYCLE:    return m_cycle[31:0];
        CSR_CYCLEH:   return m_cycle[63:32];
        default:      return '0;  // mhartid and unknown
    endcase
endfunction

task automatic store_csr(input logic [11:0] addr, input logic [31:0] v);
    logic [31:0] s;
    s = v & 32'h0000_0088;  // MIE and MPIE
    if (v[12:11] != 2'b00) begin
        s[12:11] = 2'b11;
    end
    case (addr)
        CSR_MSTATUS:  m_status   = s;
        CSR_MIE:      m_mie      = v;
        CSR_MTVEC:    m_mtvec    = v;
        CSR_MSCRATCH: m_mscratch = v;
        CSR_MEPC:     m_mepc     = v;
        CSR_MCAUSE:   m_mcause   = v;
        CSR_MTVAL:    m_mtval    = v;
        CSR_MIP:      m_mip_sw   = v & 32'h0000_0888;  // software bits only
        default:      ;
    endcase
endtask

// one cycle of the unit, returns the writeback item it should produce
task automatic predict(input stage_in_t ins, input logic [31:0] data, input logic flush,
                       input logic [2:0] ints, output logic ev, output logic er,
                       output logic [31:0] ed);
    logic        trap;
    logic [31:0] cause;
    logic [31:0] tval;
    logic [31:0] pend;
    logic [31:0] old;
    logic [31:0] nv;
    logic [4:0]  icode;
    trap  = 1'b0;
    cause = '0;
    tval  = '0;
    ev    = ins.valid && !flush;
    er    = 1'b0;
    ed    = data;
    pend  = mip_view(ints) & m_mie;
    if (ins.valid && ins.except_valid) begin
        if (ins.except_code == EXC_MARK_INT) begin
            if (pend[11]) begin
                icode = 5'd11;
            end else if (pend[3]) begin
                icode = 5'd3;
            end else if (pend[7]) begin
                icode = 5'd7;
            end else begin
                icode = 5'd0;
            end
            trap  = 1'b1;
            cause = {1'b1, 26'd0, icode};
        end else if (ins.except_code == EXC_MARK_SYS) begin
            case (ins.sys_op)
                SYS_ECALL: begin
                    trap  = 1'b1;
                    cause = (m_priv == 2'b00) ? {27'd0, CAUSE_ECALL_U} : {27'd0, CAUSE_ECALL_M};
                end
                SYS_EBREAK: begin
                    trap  = 1'b1;
                    cause = {27'd0, CAUSE_EBREAK};
                    tval  = ins.pc;
                end
                SYS_MRET: begin
                    er = 1'b1;
                    ed = {m_mepc[31:1], 1'b0};
                    if (!flush) begin
                        m_status[3] = m_status[7];
                        m_priv      = m_status[12:11];
                    end
                end
                SYS_CSR_SWAP, SYS_CSR_SET, SYS_CSR_CLEAR: begin
                    old = lookup_csr(ins.csr_addr, ints);
                    ed  = old;
                    if (ins.sys_op == SYS_CSR_SWAP) begin
                        nv = data;
                    end else if (ins.sys_op == SYS_CSR_SET) begin
                        nv = old | data;
                    end else begin
                        nv = old & ~data;
                    end
                    if (!flush) begin
                        store_csr(ins.csr_addr, nv);
                    end
                end
                default: ;  // other trap, plain pass-through
            endcase
        end else begin
            trap  = 1'b1;  // standard exception
            cause = {27'd0, ins.except_code};
            tval  = ins.tval;
        end
    end
    if (trap) begin
        er = 1'b1;
        ed = m_mtvec;
        if (!flush) begin
            m_mepc          = ins.pc;
            m_mcause        = cause;
            m_mtval         = tval;
            m_status[12:11] = m_priv;
            m_status[7]     = m_status[3];
            m_status[3]     = 1'b0;
            m_priv          = 2'b11;
        end
    end
    er      = er && ev;
    m_cycle = m_cycle + 64'd1;  // counts through flush
endtask

`endif

// File: test/tb_csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit;
    import csr_isa_pkg::*;
    import csr_pipe_pkg::*;

    localparam int          CLK_NS       = 8;
    localparam int          RAND_CYCLES  = 3000;
    localparam int          FIXED_CYCLES = 120;  // upper bound for the directed tests
    localparam logic [31:0] SEED         = 32'h1888_1b75;

    logic         i_clk;
    logic         i_rst_n;
    stage_in_t    i_instr;
    logic [31:0]  i_data;
    logic         i_flush;
    logic         i_int_ext;
    logic         i_int_timer;
    logic         i_int_soft;
    wb_out_t      o_wb;
    logic [31:0]  o_data;
    priv_t        o_priv;
    logic [31:0]  o_status;
    logic [11:0]  o_intp;
    logic [11:0]  o_inte;

    logic         exp_valid;
    logic         exp_redirect;
    logic [31:0]  exp_data;
    logic [31:0]  exp_pc;
    logic [2:0]   levels;  // {ext, timer, soft} for directed tests
    string        test_name;
    int           test_errors;
    int           total_errors;
    int           test_count;
    int           check_count;

    `include "csr_ref_model.svh"

    csr_unit u_csr_unit (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_instr     (i_instr),
        .i_data      (i_data),
        .i_flush     (i_flush),
        .i_int_ext   (i_int_ext),
        .i_int_timer (i_int_timer),
        .i_int_soft  (i_int_soft),
        .o_wb        (o_wb),
        .o_data      (o_data),
        .o_priv      (o_priv),
        .o_status    (o_status),
        .o_intp      (o_intp),
        .o_inte      (o_inte)
    );

    always #(CLK_NS / 2) i_clk = ~i_clk;

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("mismatch %s %s: expected %h actual %h", test_name, what, expected, actual);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic check_outputs(input logic [2:0] ints);
        logic [31:0] mip;
        mip = mip_view(ints);
        compare("valid", 32'(exp_valid), 32'(o_wb.valid));
        compare("redirect", 32'(exp_redirect), 32'(o_wb.redirect));
        if (exp_valid) begin  // pc and data mean nothing on a bubble
            compare("pc", exp_pc, o_wb.pc);
            compare("data", exp_data, o_data);
        end
        compare("priv", 32'(m_priv), 32'(o_priv));
        compare("mstatus", m_status, o_status);
        compare("inte", 32'(m_mie[11:0]), 32'(o_inte));
        compare("intp", 32'(mip[11:0]), 32'(o_intp));
    endtask

    // drive on the edge, check mid-cycle, then advance the model
    task automatic issue(input stage_in_t ins, input logic [31:0] data, input logic flush,
                         input logic [2:0] ints);
        logic        nv;
        logic        nr;
        logic [31:0] nd;
        @(posedge i_clk);
        i_instr     <= ins;
        i_data      <= data;
        i_flush     <= flush;
        i_int_ext   <= ints[2];
        i_int_timer <= ints[1];
        i_int_soft  <= ints[0];
        @(negedge i_clk);
        check_outputs(ints);
        predict(ins, data, flush, ints, nv, nr, nd);
        exp_valid    = nv;
        exp_redirect = nr;
        exp_data     = nd;
        exp_pc       = ins.pc;
    endtask

    function automatic stage_in_t make_instr(input logic [31:0] pc, input logic flagged,
                                             input logic [4:0] code, input logic [31:0] tval,
                                             input sys_op_t op, input logic [11:0] addr);
        stage_in_t s;
        s.valid        = 1'b1;
        s.pc           = pc;
        s.except_valid = flagged;
        s.except_code  = code;
        s.tval         = tval;
        s.sys_op       = op;
        s.csr_addr     = addr;
        return s;
    endfunction

    task automatic access_csr(input sys_op_t op, input logic [11:0] addr, input logic [31:0] v);
        issue(make_instr(32'h0000_1000, 1'b1, EXC_MARK_SYS, '0, op, addr), v, 1'b0, levels);
    endtask

    task automatic read_csr(input logic [11:0] addr);
        access_csr(SYS_CSR_SET, addr, '0);  // set with zero leaves the value
    endtask

    task automatic sys_instr(input sys_op_t op, input logic [31:0] pc);
        issue(make_instr(pc, 1'b1, EXC_MARK_SYS, '0, op, '0), '0, 1'b0, levels);
    endtask

    task automatic raise(input logic [4:0] code, input logic [31:0] pc, input logic [31:0] tval);
        issue(make_instr(pc, 1'b1, code, tval, SYS_NONE, '0), '0, 1'b0, levels);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        issue('0, '0, 1'b0, levels);  // bubble so the last result gets checked
        test_count++;
        $display("test %s finished with %0d errors", test_name, test_errors);
    endtask

    function automatic logic [11:0] pick_addr();
        case ($urandom_range(13))
            0:       return CSR_MSTATUS;
            1:       return CSR_MISA;
            2:       return CSR_MIE;
            3:       return CSR_MTVEC;
            4:       return CSR_MSCRATCH;
            5:       return CSR_MEPC;
            6:       return CSR_MCAUSE;
            7:       return CSR_MTVAL;
            8:       return CSR_MIP;
            9:       return CSR_CYCLE;
            10:      return CSR_CYCLEH;
            11:      return CSR_MHARTID;
            default: return 12'(12'h7c0 + $urandom_range(15));  // unknown
        endcase
    endfunction

    task automatic random_cycle();
        stage_in_t s;
        int        r;
        r = $urandom_range(99);
        s = make_instr($urandom, 1'b1, EXC_MARK_SYS, $urandom, SYS_NONE, pick_addr());
        if (r < 36) begin
            case ($urandom_range(2))
                0:       s.sys_op = SYS_CSR_SWAP;
                1:       s.sys_op = SYS_CSR_SET;
                default: s.sys_op = SYS_CSR_CLEAR;
            endcase
        end else if (r < 46) begin
            s.except_code = 5'($urandom_range(15));
        end else if (r < 54) begin
            s.sys_op = SYS_ECALL;
        end else if (r < 59) begin
            s.sys_op = SYS_EBREAK;
        end else if (r < 66) begin
            s.sys_op = SYS_MRET;
        end else if (r < 74) begin
            s.except_code = EXC_MARK_INT;
        end else if (r < 78) begin
            s.sys_op = SYS_NONE;  // other trap
        end else if (r < 94) begin
            s.except_valid = 1'b0;  // plain
        end else begin
            s.valid = 1'b0;
        end
        issue(s, $urandom, ($urandom_range(9) == 0), 3'($urandom_range(7)));
    endtask

    initial begin
        #((RAND_CYCLES + FIXED_CYCLES + 50) * CLK_NS);
        $display("watchdog expired before the tests completed");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        i_clk        = 1'b0;
        i_rst_n      = 1'b0;
        i_instr      = '0;
        i_data       = '0;
        i_flush      = 1'b0;
        i_int_ext    = 1'b0;
        i_int_timer  = 1'b0;
        i_int_soft   = 1'b0;
        exp_valid    = 1'b0;
        exp_redirect = 1'b0;
        exp_data     = '0;
        exp_pc       = '0;
        levels       = 3'b000;
        total_errors = 0;
        test_count   = 0;
        check_count  = 0;
        init_state();
        repeat (2) @(posedge i_clk);
        i_rst_n <= 1'b1;

        start_test("csr_rw");
        access_csr(SYS_CSR_SWAP, CSR_MSCRATCH, 32'hcafe_0f0f);
        access_csr(SYS_CSR_SET, CSR_MSCRATCH, 32'h0000_f000);
        access_csr(SYS_CSR_CLEAR, CSR_MSCRATCH, 32'h0000_0f00);
        read_csr(CSR_MSCRATCH);
        access_csr(SYS_CSR_SWAP, CSR_MTVEC, 32'h0000_0100);
        read_csr(CSR_MTVEC);
        access_csr(SYS_CSR_SET, CSR_MIE, 32'h0000_0888);
        access_csr(SYS_CSR_CLEAR, CSR_MIE, 32'h0000_0008);
        read_csr(CSR_MIE);
        read_csr(CSR_MISA);
        read_csr(12'h7c3);
        read_csr(CSR_MHARTID);
        finish_test();

        start_test("exception");
        raise(5'd5, 32'h0000_0200, 32'h0000_dead);
        read_csr(CSR_MEPC);
        read_csr(CSR_MCAUSE);
        read_csr(CSR_MTVAL);
        finish_test();

        start_test("ecall_ebreak");
        sys_instr(SYS_ECALL, 32'h0000_0300);  // from machine
        read_csr(CSR_MCAUSE);
        access_csr(SYS_CSR_CLEAR, CSR_MSTATUS, 32'h0000_1800);  // MPP to user
        access_csr(SYS_CSR_SWAP, CSR_MEPC, 32'h0000_0400);
        sys_instr(SYS_MRET, 32'h0000_0304);
        sys_instr(SYS_ECALL, 32'h0000_0400);  // from user
        read_csr(CSR_MCAUSE);
        sys_instr(SYS_EBREAK, 32'h0000_0404);
        read_csr(CSR_MTVAL);
        read_csr(CSR_MCAUSE);
        finish_test();

        start_test("mret");
        access_csr(SYS_CSR_SWAP, CSR_MSTATUS, 32'h0000_1880);
        access_csr(SYS_CSR_SWAP, CSR_MEPC, 32'h0000_0501);  // bit 0 dropped on return
        sys_instr(SYS_MRET, 32'h0000_0600);
        read_csr(CSR_MSTATUS);
        access_csr(SYS_CSR_CLEAR, CSR_MSTATUS, 32'h0000_1808);
        sys_instr(SYS_MRET, 32'h0000_0604);
        finish_test();

        start_test("interrupt");
        access_csr(SYS_CSR_SWAP, CSR_MIE, 32'h0000_0888);
        access_csr(SYS_CSR_SWAP, CSR_MTVEC, 32'h0000_0800);
        levels = 3'b011;
        raise(EXC_MARK_INT, 32'h0000_0700, '0);
        read_csr(CSR_MCAUSE);
        levels = 3'b111;
        raise(EXC_MARK_INT, 32'h0000_0704, '0);
        read_csr(CSR_MCAUSE);
        levels = 3'b010;
        raise(EXC_MARK_INT, 32'h0000_0708, '0);
        levels = 3'b000;
        access_csr(SYS_CSR_SET, CSR_MIP, 32'h0000_0888);  // software copies of all three
        read_csr(CSR_MIP);
        raise(EXC_MARK_INT, 32'h0000_070c, '0);
        read_csr(CSR_MCAUSE);
        read_csr(CSR_CYCLE);
        repeat (5) issue(make_instr(32'h0000_0710, 1'b0, '0, '0, SYS_NONE, '0),
                         32'h1234_5678, 1'b0, levels);
        read_csr(CSR_CYCLE);
        read_csr(CSR_CYCLEH);
        finish_test();

        start_test("flush");
        access_csr(SYS_CSR_SWAP, CSR_MSCRATCH, 32'h1111_0000);
        issue(make_instr(32'h0000_0900, 1'b1, EXC_MARK_SYS, '0, SYS_CSR_SWAP, CSR_MSCRATCH),
              32'h2222_0000, 1'b1, levels);
        issue(make_instr(32'h0000_0904, 1'b1, EXC_MARK_SYS, '0, SYS_ECALL, '0), '0, 1'b1, levels);
        issue(make_instr(32'h0000_0908, 1'b1, 5'd2, 32'h55, SYS_NONE, '0), '0, 1'b1, levels);
        read_csr(CSR_MSCRATCH);
        read_csr(CSR_MEPC);
        finish_test();

        start_test("random");
        repeat (RAND_CYCLES) random_cycle();
        finish_test();

        $display("%0d tests run, %0d checks, %0d errors", test_count, check_count, total_errors);
        if (total_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+test
verilog/csr_isa_pkg.sv
verilog/csr_pipe_pkg.sv
verilog/sys_event_decode.sv
verilog/machine_csr_file.sv
verilog/wb_stage_reg.sv
verilog/csr_unit.sv
test/tb_csr_unit.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_csr_unit -f src.f -o sim_csr_unit

out="$(./obj_dir/sim_csr_unit 2>&1)"
echo "$out"
if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
